// ==== hdl/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Address width of the APB link between the command decoder and the
// UART register block
// Only bits 4:2 are decoded, the rest must be zero
`define APB_AW 8

// APB data width, one byte to match the SPI payload byte
`define APB_DW 8

// Number of transmit-only UART channels behind the register block
// Address bit 4 picks the channel, so this cannot grow past two
`define UART_CHANNELS 2

// Core clock cycles per UART bit
// A full frame of start, eight data and stop bits is ten of these
`define UART_CLKS_PER_BIT 16

// Bytes in one SPI command frame
// Opcode first, then address, then data
`define SPI_FRAME_BYTES 3

`endif

// ==== hdl/spi_cmd_pkg.sv ====
// Types that describe the SPI command protocol seen by the external master
package spi_cmd_pkg;

  // Command opcodes carried in the first byte of a frame
  // Any other value turns the frame into a no-op
  typedef enum logic [7:0] {
    CMD_WRITE = 8'h02,
    CMD_READ  = 8'h03
  } opcode_e;

  // One complete command frame
  // The first byte on the wire sits in the top bits, so a frame can be
  // built by shifting bytes in from the right
  typedef struct packed {
    opcode_e    opcode;
    logic [7:0] addr;
    logic [7:0] data;
  } spi_frame_t;

  // Byte framing in the SPI target
  // IDLE waits for CSB to fall, SHIFT counts SCK edges inside a frame
  typedef enum logic {
    IDLE,
    SHIFT
  } spi_state_e;

endpackage

// ==== hdl/periph_bus_pkg.sv ====
`include "soc_params.svh"

// Types that describe the peripheral side, from the APB link to the pads
package periph_bus_pkg;

  // APB request driven by the command decoder
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [`APB_AW-1:0] paddr;
    logic [`APB_DW-1:0] pwdata;
  } apb_req_t;

  // APB response from the register block
  // pslverr is only meaningful in the cycle where pready is high
  typedef struct packed {
    logic [`APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // Register index taken from address bits 3:2
  // Index 3 is not backed by any register and answers with an error
  typedef enum logic [1:0] {
    REG_TXDATA  = 2'd0,
    REG_STATUS  = 2'd1,
    REG_SCRATCH = 2'd2,
    REG_RSVD    = 2'd3
  } reg_idx_e;

  // Pad-side outputs of one UART channel
  typedef struct packed {
    logic cio_tx;
    logic cio_tx_en;
  } uart_sideband_o_t;

  // Phases of one UART transmit frame
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } tx_state_e;

endpackage

// ==== hdl/spi_target.sv ====
`timescale 1ns/100ps

// SPI mode-0 target running entirely in the core clock domain
module spi_target (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       spi_clk_i,
  input  logic       spi_csb_i,
  input  logic       spi_mosi_i,
  output logic       spi_miso_o,
  input  logic [7:0] tx_byte_i,
  output logic       frame_start_o,
  output logic       rx_valid_o,
  output logic [7:0] rx_byte_o
);

  // Two-flop synchronisers, with one extra stage on SCK and CSB for edge detection
  logic [2:0] sck_q;
  logic [2:0] csb_q;
  logic [1:0] mosi_q;

  logic sck_rise;
  logic sck_fall;
  logic csb_fall;
  logic csb_s;
  logic mosi_s;
  logic shift_en;

  spi_cmd_pkg::spi_state_e state_q;
  logic [2:0]              bit_cnt_q;
  logic [7:0]              rx_shift_q;
  logic [7:0]              tx_shift_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_q  <= '0;
      csb_q  <= '1;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], spi_clk_i};
      csb_q  <= {csb_q[1:0], spi_csb_i};
      mosi_q <= {mosi_q[0], spi_mosi_i};
    end
  end

  // Bit 1 is the synchronised level, bit 2 its value one cycle earlier
  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign csb_fall = ~csb_q[1] & csb_q[2];
  assign csb_s    = csb_q[1];
  assign mosi_s   = mosi_q[1];

  // SCK edges only count inside a selected frame
  assign shift_en = (state_q == spi_cmd_pkg::SHIFT) && !csb_s && !csb_fall;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= spi_cmd_pkg::IDLE;
      bit_cnt_q     <= '0;
      frame_start_o <= 1'b0;
      rx_valid_o    <= 1'b0;
      spi_miso_o    <= 1'b0;
    end else begin
      frame_start_o <= csb_fall;
      rx_valid_o    <= 1'b0;
      if (csb_fall) begin
        // The MSB of the reply has to be on MISO before the first SCK rise
        state_q    <= spi_cmd_pkg::SHIFT;
        bit_cnt_q  <= '0;
        spi_miso_o <= tx_byte_i[7];
      end else if (state_q == spi_cmd_pkg::SHIFT && csb_s) begin
        // Deselect drops whatever part of a byte was collected
        state_q    <= spi_cmd_pkg::IDLE;
        spi_miso_o <= 1'b0;
      end else if (shift_en) begin
        if (sck_rise) begin
          // Counter wraps from 7 back to 0 at each byte boundary
          bit_cnt_q  <= bit_cnt_q + 3'd1;
          rx_valid_o <= (bit_cnt_q == 3'd7);
        end
        if (sck_fall) begin
          spi_miso_o <= tx_shift_q[6];
        end
      end
    end
  end

  // Data shifters
  // Zeros shift in behind the reply, so every later byte of the frame answers 0
  always_ff @(posedge clk_i) begin
    if (csb_fall) begin
      tx_shift_q <= tx_byte_i;
    end else if (shift_en && sck_fall) begin
      tx_shift_q <= {tx_shift_q[6:0], 1'b0};
    end
    if (shift_en && sck_rise) begin
      rx_shift_q <= {rx_shift_q[6:0], mosi_s};
      if (bit_cnt_q == 3'd7) begin
        rx_byte_o <= {rx_shift_q[6:0], mosi_s};
      end
    end
  end

endmodule

// ==== hdl/spi_cmd_decoder.sv ====
`timescale 1ns/100ps
`include "soc_params.svh"

// Turns complete SPI frames into single APB transfers
module spi_cmd_decoder (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      frame_start_i,
  input  logic                      rx_valid_i,
  input  logic [7:0]                rx_byte_i,
  output logic [7:0]                tx_byte_o,
  output periph_bus_pkg::apb_req_t  apb_req_o,
  input  periph_bus_pkg::apb_rsp_t  apb_rsp_i
);

  // APB master phases, local to this block
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  apb_state_e state_q;
  logic [1:0] byte_cnt_q;

  // One-byte holding slot for a byte that lands while a transfer is stalled
  logic       hold_vld_q;
  logic [7:0] hold_q;

  logic       byte_vld;
  logic [7:0] byte_dat;
  logic       take;
  logic       frame_done;
  logic       cmd_known;

  spi_cmd_pkg::spi_frame_t  frame_q;
  spi_cmd_pkg::spi_frame_t  frame_nxt;
  periph_bus_pkg::apb_req_t req_q;
  logic [7:0]               reply_q;

  // A held byte is older than anything arriving now, so it goes first
  assign byte_vld = rx_valid_i | hold_vld_q;
  assign byte_dat = hold_vld_q ? hold_q : rx_byte_i;

  // Bytes are only taken while no transfer is open
  assign take = byte_vld && (state_q == APB_IDLE);

  // Frame as it looks with the current byte shifted in
  assign frame_nxt  = spi_cmd_pkg::spi_frame_t'({frame_q.addr, frame_q.data, byte_dat});
  assign frame_done = take && (byte_cnt_q == 2'(`SPI_FRAME_BYTES - 1));
  assign cmd_known  = frame_nxt.opcode inside {spi_cmd_pkg::CMD_WRITE, spi_cmd_pkg::CMD_READ};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      byte_cnt_q <= '0;
      hold_vld_q <= 1'b0;
    end else begin
      if (frame_start_i) begin
        byte_cnt_q <= '0;
        hold_vld_q <= 1'b0;
      end else begin
        if (take) begin
          byte_cnt_q <= frame_done ? 2'd0 : byte_cnt_q + 2'd1;
        end
        // Keep the slot full if a new byte arrives as the old one drains
        if (rx_valid_i && (state_q != APB_IDLE || hold_vld_q)) begin
          hold_vld_q <= 1'b1;
        end else if (take) begin
          hold_vld_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      hold_q <= rx_byte_i;
    end
    if (take) begin
      frame_q <= frame_nxt;
    end
  end

  // APB master
  // Request fields are registered so they stay stable through the access phase
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= APB_IDLE;
      req_q   <= '0;
      reply_q <= '0;
    end else begin
      case (state_q)
        APB_IDLE: begin
          if (frame_done) begin
            // Each frame starts with a zero reply, a read overwrites it later
            reply_q <= '0;
            if (cmd_known) begin
              req_q.psel   <= 1'b1;
              req_q.pwrite <= (frame_nxt.opcode == spi_cmd_pkg::CMD_WRITE);
              req_q.paddr  <= frame_nxt.addr;
              req_q.pwdata <= frame_nxt.data;
              state_q      <= APB_SETUP;
            end
          end
        end
        APB_SETUP: begin
          req_q.penable <= 1'b1;
          state_q       <= APB_ACCESS;
        end
        APB_ACCESS: begin
          if (apb_rsp_i.pready) begin
            req_q.psel    <= 1'b0;
            req_q.penable <= 1'b0;
            state_q       <= APB_IDLE;
            if (!req_q.pwrite) begin
              reply_q <= apb_rsp_i.pslverr ? 8'hFF : apb_rsp_i.prdata;
            end
          end
        end
        default: state_q <= APB_IDLE;
      endcase
    end
  end

  assign apb_req_o = req_q;
  assign tx_byte_o = reply_q;

endmodule

// ==== hdl/uart_apb_regs.sv ====
`timescale 1ns/100ps
`include "soc_params.svh"

// APB register block for the UART transmit channels
module uart_apb_regs (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  periph_bus_pkg::apb_req_t                apb_req_i,
  output periph_bus_pkg::apb_rsp_t                apb_rsp_o,
  output logic [`UART_CHANNELS-1:0]               tx_valid_o,
  output logic [`UART_CHANNELS-1:0][`APB_DW-1:0]  tx_data_o,
  input  logic [`UART_CHANNELS-1:0]               tx_ready_i
);

  logic                     access;
  logic                     ch_sel;
  periph_bus_pkg::reg_idx_e idx;
  logic                     mapped;
  logic                     txdata_wr;
  logic                     ready;
  logic                     wr_done;

  logic [`UART_CHANNELS-1:0][`APB_DW-1:0] scratch_q;
  logic [`UART_CHANNELS-1:0][3:0]         count_q;

  assign access = apb_req_i.psel & apb_req_i.penable;

  // Bit 4 is the channel, bits 3:2 the register, everything else must be zero
  assign ch_sel = apb_req_i.paddr[4];
  assign idx    = periph_bus_pkg::reg_idx_e'(apb_req_i.paddr[3:2]);
  assign mapped = (apb_req_i.paddr[`APB_AW-1:5] == '0) &&
                  (apb_req_i.paddr[1:0] == 2'b00) &&
                  (idx != periph_bus_pkg::REG_RSVD);

  // Only a TXDATA write can wait, and only until its serialiser is free
  assign txdata_wr = mapped && apb_req_i.pwrite && (idx == periph_bus_pkg::REG_TXDATA);
  assign ready     = txdata_wr ? tx_ready_i[ch_sel] : 1'b1;
  assign wr_done   = access && ready && apb_req_i.pwrite && mapped;

  always_comb begin
    apb_rsp_o.pready  = ready;
    apb_rsp_o.pslverr = ~mapped;
    apb_rsp_o.prdata  = '0;
    if (mapped && !apb_req_i.pwrite) begin
      case (idx)
        // Busy in bit 0, accepted byte count in the upper nibble
        periph_bus_pkg::REG_STATUS: begin
          apb_rsp_o.prdata = {count_q[ch_sel], 3'b000, ~tx_ready_i[ch_sel]};
        end
        periph_bus_pkg::REG_SCRATCH: begin
          apb_rsp_o.prdata = scratch_q[ch_sel];
        end
        // TXDATA is write-only and reads back as zero
        default: begin
          apb_rsp_o.prdata = '0;
        end
      endcase
    end
  end

  // Valid is raised in the very cycle the write completes
  // The serialiser takes the byte on the same edge that ends the APB access
  for (genvar ch = 0; ch < `UART_CHANNELS; ch++) begin : g_chan
    assign tx_valid_o[ch] = access && txdata_wr && (ch_sel == 1'(ch)) && tx_ready_i[ch];
    assign tx_data_o[ch]  = apb_req_i.pwdata;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scratch_q <= '0;
      count_q   <= '0;
    end else if (wr_done) begin
      case (idx)
        periph_bus_pkg::REG_SCRATCH: begin
          scratch_q[ch_sel] <= apb_req_i.pwdata;
        end
        // Counter wraps at 16, which is what STATUS reports
        periph_bus_pkg::REG_TXDATA: begin
          count_q[ch_sel] <= count_q[ch_sel] + 4'd1;
        end
        // STATUS writes are accepted and ignored
        default: begin
          count_q <= count_q;
        end
      endcase
    end
  end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/100ps
`include "soc_params.svh"

// UART transmitter for one channel, 8N1, LSB first
module uart_tx (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               tx_valid_i,
  input  logic [7:0]                         tx_data_i,
  output logic                               tx_ready_o,
  output periph_bus_pkg::uart_sideband_o_t   sideband_o
);

  periph_bus_pkg::tx_state_e                state_q;
  logic [$clog2(`UART_CLKS_PER_BIT)-1:0]    clk_cnt_q;
  logic [2:0]                               bit_cnt_q;
  logic [7:0]                               shift_q;
  logic                                     tx_q;
  logic                                     bit_end;

  // Last clock of the current bit period
  assign bit_end = (clk_cnt_q == ($clog2(`UART_CLKS_PER_BIT))'(`UART_CLKS_PER_BIT - 1));

  // Ready drops at acceptance and comes back as the stop bit ends
  assign tx_ready_o = (state_q == periph_bus_pkg::IDLE);

  // Transmit-only pad, so the output enable never drops
  assign sideband_o = '{cio_tx: tx_q, cio_tx_en: 1'b1};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= periph_bus_pkg::IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      tx_q      <= 1'b1;
    end else begin
      // Bit timer runs for the whole frame and restarts at each bit boundary
      if (state_q != periph_bus_pkg::IDLE) begin
        clk_cnt_q <= bit_end ? '0 : clk_cnt_q + 1'b1;
      end
      case (state_q)
        periph_bus_pkg::IDLE: begin
          if (tx_valid_i) begin
            // Start bit goes out on the edge that accepts the byte
            state_q   <= periph_bus_pkg::START;
            clk_cnt_q <= '0;
            tx_q      <= 1'b0;
          end
        end
        periph_bus_pkg::START: begin
          if (bit_end) begin
            state_q   <= periph_bus_pkg::DATA;
            bit_cnt_q <= '0;
            tx_q      <= shift_q[0];
          end
        end
        periph_bus_pkg::DATA: begin
          if (bit_end) begin
            if (bit_cnt_q == 3'd7) begin
              state_q <= periph_bus_pkg::STOP;
              tx_q    <= 1'b1;
            end else begin
              // The shifter moves on the same edge, so bit 1 is the next one
              bit_cnt_q <= bit_cnt_q + 3'd1;
              tx_q      <= shift_q[1];
            end
          end
        end
        default: begin
          // Stop bit, line already high
          if (bit_end) begin
            state_q <= periph_bus_pkg::IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == periph_bus_pkg::IDLE && tx_valid_i) begin
      shift_q <= tx_data_i;
    end else if (state_q == periph_bus_pkg::DATA && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

// ==== hdl/chip_top.sv ====
`timescale 1ns/100ps
`include "soc_params.svh"

// Debug-access top level
// SPI frames come in and end up as APB writes that feed the UART serialisers
module chip_top (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  input  logic                                               spi_clk_i,
  input  logic                                               spi_csb_i,
  input  logic                                               spi_mosi_i,
  output logic                                               spi_miso_o,
  output periph_bus_pkg::uart_sideband_o_t [`UART_CHANNELS-1:0] uart_sideband_o
);

  logic       frame_start;
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic [7:0] tx_byte;

  periph_bus_pkg::apb_req_t apb_req;
  periph_bus_pkg::apb_rsp_t apb_rsp;

  logic [`UART_CHANNELS-1:0]              tx_valid;
  logic [`UART_CHANNELS-1:0]              tx_ready;
  logic [`UART_CHANNELS-1:0][`APB_DW-1:0] tx_data;

  // Byte-level SPI target on the pins
  spi_target i_spi_target (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .spi_clk_i     (spi_clk_i),
    .spi_csb_i     (spi_csb_i),
    .spi_mosi_i    (spi_mosi_i),
    .spi_miso_o    (spi_miso_o),
    .tx_byte_i     (tx_byte),
    .frame_start_o (frame_start),
    .rx_valid_o    (rx_valid),
    .rx_byte_o     (rx_byte)
  );

  // Frame assembly and APB master
  spi_cmd_decoder i_spi_cmd_decoder (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .frame_start_i (frame_start),
    .rx_valid_i    (rx_valid),
    .rx_byte_i     (rx_byte),
    .tx_byte_o     (tx_byte),
    .apb_req_o     (apb_req),
    .apb_rsp_i     (apb_rsp)
  );

  uart_apb_regs i_uart_apb_regs (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .tx_valid_o (tx_valid),
    .tx_data_o  (tx_data),
    .tx_ready_i (tx_ready)
  );

  // One serialiser per channel
  for (genvar ch = 0; ch < `UART_CHANNELS; ch++) begin : g_uart
    uart_tx i_uart_tx (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .tx_valid_i (tx_valid[ch]),
      .tx_data_i  (tx_data[ch]),
      .tx_ready_o (tx_ready[ch]),
      .sideband_o (uart_sideband_o[ch])
    );
  end

endmodule

// ==== sim/chip_top_checker.sv ====
`timescale 1ns/100ps
`include "soc_params.svh"

// Protocol checker bound into the UART register block
// It sees the APB link from the slave side and the pad lines of every channel
module chip_top_checker (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  periph_bus_pkg::apb_req_t                             apb_req_i,
  input  periph_bus_pkg::apb_rsp_t                             apb_rsp_i,
  input  logic [`UART_CHANNELS-1:0]                            tx_ready_i,
  input  periph_bus_pkg::uart_sideband_o_t [`UART_CHANNELS-1:0] sideband_i
);

  // Number of assertion failures, read by the testbench at the end of the run
  int unsigned fail_cnt;

  initial fail_cnt = 0;

  // A stalled access phase must keep every request field unchanged
  a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (apb_req_i.penable && !apb_rsp_i.pready) |=> $stable(apb_req_i))
    else begin
      $error("APB request changed while the access phase was stalled");
      fail_cnt++;
    end

  // The access phase only exists inside a selected transfer
  a_enable_sel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      apb_req_i.penable |-> apb_req_i.psel)
    else begin
      $error("APB penable seen without psel");
      fail_cnt++;
    end

  // An idle serialiser leaves its line in the mark state
  for (genvar ch = 0; ch < `UART_CHANNELS; ch++) begin : g_line
    a_idle_high: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tx_ready_i[ch] |-> sideband_i[ch].cio_tx)
      else begin
        $error("UART line %0d is low while its channel is idle", ch);
        fail_cnt++;
      end
  end

endmodule

// ==== sim/chip_top_tb.sv ====
`timescale 1ns/100ps
`include "soc_params.svh"

// Testbench for the debug-access top level
// SPI frames go in, MISO replies and UART bytes are checked against a model
module chip_top_tb;

  localparam int CLK_HALF_NS     = 4;
  localparam int CLK_NS          = 2 * CLK_HALF_NS;
  localparam int SCK_HALF_CLKS   = 8;
  localparam int NUM_FRAMES      = 25;
  localparam int UART_FRAME_CLKS = 10 * `UART_CLKS_PER_BIT;
  // Each frame is 24 SCK bits of 16 clocks, then twice that for margin
  localparam int WATCHDOG_CLKS   = 2 * (NUM_FRAMES * 24 * 2 * SCK_HALF_CLKS + UART_FRAME_CLKS)
                                   + 16;

  logic clk_i;
  logic arst_n_i;
  logic spi_clk_i;
  logic spi_csb_i;
  logic spi_mosi_i;
  logic spi_miso_o;
  periph_bus_pkg::uart_sideband_o_t [`UART_CHANNELS-1:0] uart_sb;

  // Reference model state
  logic [`APB_DW-1:0] scratch_m [`UART_CHANNELS];
  logic [3:0]         count_m [`UART_CHANNELS];
  realtime            busy_until_m [`UART_CHANNELS];
  logic [`APB_DW-1:0] next_reply;
  realtime            last_rise_t;

  // Expected and observed results, drained by the compare process
  logic [`APB_DW-1:0] exp_reply_q [$];
  logic [`APB_DW-1:0] got_reply_q [$];
  logic [7:0]         uart_exp_q [`UART_CHANNELS][$];
  logic [7:0]         uart_got_q [`UART_CHANNELS][$];

  int          seed;
  int          value_errs;
  int          other_errs;
  int unsigned asrt_errs;

  chip_top chip_top_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .spi_clk_i       (spi_clk_i),
    .spi_csb_i       (spi_csb_i),
    .spi_mosi_i      (spi_mosi_i),
    .spi_miso_o      (spi_miso_o),
    .uart_sideband_o (uart_sb)
  );

  bind uart_apb_regs chip_top_checker i_chip_top_checker (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .apb_req_i  (apb_req_i),
    .apb_rsp_i  (apb_rsp_o),
    .tx_ready_i (tx_ready_i),
    .sideband_i (chip_top_tb.chip_top_i.uart_sideband_o)
  );

  always #(CLK_HALF_NS) clk_i = ~clk_i;

  // All drives land 1 ns after a rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // Mode-0 master, MSB first, one SCK bit is 16 clocks
  task automatic spi_xfer(input spi_cmd_pkg::spi_frame_t frame, output logic [23:0] miso);
    logic [23:0] bits;
    bits      = frame;
    spi_csb_i = 1'b0;
    for (int i = 23; i >= 0; i--) begin
      spi_mosi_i = bits[i];
      wait_clks(SCK_HALF_CLKS);
      // MISO moved on the previous falling edge and has settled by now
      miso[i]     = spi_miso_o;
      spi_clk_i   = 1'b1;
      last_rise_t = $realtime;
      wait_clks(SCK_HALF_CLKS);
      spi_clk_i = 1'b0;
    end
    wait_clks(SCK_HALF_CLKS);
    spi_csb_i = 1'b1;
    wait_clks(2 * SCK_HALF_CLKS);
  endtask

  // Only bits 4:2 may be set, and register index 3 has no backing
  function automatic bit is_mapped(input logic [`APB_AW-1:0] addr);
    return (addr[`APB_AW-1:5] == '0) && (addr[1:0] == 2'b00) && (addr[3:2] != 2'd3);
  endfunction

  // Predicted read data for an access at time t
  function automatic logic [`APB_DW-1:0] model_read(input logic [`APB_AW-1:0] addr,
                                                    input realtime t);
    int ch;
    ch = int'(addr[4]);
    if (!is_mapped(addr)) begin
      return 8'hFF;
    end
    case (periph_bus_pkg::reg_idx_e'(addr[3:2]))
      periph_bus_pkg::REG_STATUS:  return {count_m[ch], 3'b000, t < busy_until_m[ch]};
      periph_bus_pkg::REG_SCRATCH: return scratch_m[ch];
      default:                     return 8'h00;
    endcase
  endfunction

  function automatic void model_write(input logic [`APB_AW-1:0] addr,
                                      input logic [`APB_DW-1:0] data, input realtime t);
    int ch;
    ch = int'(addr[4]);
    if (is_mapped(addr)) begin
      case (periph_bus_pkg::reg_idx_e'(addr[3:2]))
        periph_bus_pkg::REG_TXDATA: begin
          count_m[ch] = count_m[ch] + 4'd1;
          // Start bit within 8 cycles of the last SCK rise, or once the line frees up
          busy_until_m[ch] = ((t > busy_until_m[ch]) ? t : busy_until_m[ch])
                             + (8 + UART_FRAME_CLKS) * CLK_NS;
          uart_exp_q[ch].push_back(data);
        end
        periph_bus_pkg::REG_SCRATCH: scratch_m[ch] = data;
        default: ;
      endcase
    end
  endfunction

  // One frame on the wire, with the reply bytes queued for comparison
  task automatic run_frame(input logic [7:0] opcode, input logic [`APB_AW-1:0] addr,
                           input logic [`APB_DW-1:0] data);
    spi_cmd_pkg::spi_frame_t frame;
    logic [23:0]             miso;
    frame = spi_cmd_pkg::spi_frame_t'({opcode, addr, data});
    spi_xfer(frame, miso);
    // First byte carries the previous read, the other two are always zero
    got_reply_q.push_back(miso[23:16]);
    got_reply_q.push_back(miso[15:8]);
    got_reply_q.push_back(miso[7:0]);
    exp_reply_q.push_back(next_reply);
    exp_reply_q.push_back(8'h00);
    exp_reply_q.push_back(8'h00);
    next_reply = 8'h00;
    if (opcode == spi_cmd_pkg::CMD_WRITE) begin
      model_write(addr, data, last_rise_t);
    end else if (opcode == spi_cmd_pkg::CMD_READ) begin
      // The read executes a few cycles after the synchronised last SCK rise
      next_reply = model_read(addr, last_rise_t + 4 * CLK_NS);
    end
  endtask

  task automatic check_byte(input int idx, input logic [`APB_DW-1:0] exp,
                            input logic [`APB_DW-1:0] got);
    if (got !== exp) begin
      value_errs++;
      $display("error @%0t: frame %0d MISO byte %0d is 0x%02h, expected 0x%02h",
               $time, idx / 3, idx % 3, got, exp);
    end
  endtask

  task automatic check_uart(input int ch, input logic [7:0] got);
    logic [7:0] exp;
    if (uart_exp_q[ch].size() == 0) begin
      other_errs++;
      $display("UART channel %0d sent byte 0x%02h although no write asked for it", ch, got);
    end else begin
      exp = uart_exp_q[ch].pop_front();
      if (got !== exp) begin
        value_errs++;
        $display("error @%0t: UART channel %0d sent 0x%02h, expected 0x%02h",
                 $time, ch, got, exp);
      end
    end
  endtask

  // Decodes one channel's line, sampling each bit in its middle
  task automatic monitor_uart(input int ch);
    logic [7:0] data;
    forever begin
      @(negedge clk_i);
      if (arst_n_i && !uart_sb[ch].cio_tx) begin
        repeat (`UART_CLKS_PER_BIT / 2 - 1) @(negedge clk_i);
        if (uart_sb[ch].cio_tx) begin
          other_errs++;
          $display("UART channel %0d start bit ended before its middle", ch);
        end else begin
          // The pad has to stay enabled while a frame is on the line
          if (uart_sb[ch].cio_tx_en !== 1'b1) begin
            other_errs++;
            $display("UART channel %0d output enable dropped during a frame", ch);
          end
          for (int b = 0; b < 8; b++) begin
            repeat (`UART_CLKS_PER_BIT) @(negedge clk_i);
            data[b] = uart_sb[ch].cio_tx;
          end
          repeat (`UART_CLKS_PER_BIT) @(negedge clk_i);
          if (!uart_sb[ch].cio_tx) begin
            other_errs++;
            $display("UART channel %0d stop bit is low", ch);
          end
          uart_got_q[ch].push_back(data);
        end
      end
    end
  endtask

  function automatic bit work_pending();
    return (got_reply_q.size() != 0) || (uart_exp_q[0].size() != 0) ||
           (uart_exp_q[1].size() != 0);
  endfunction

  initial monitor_uart(0);
  initial monitor_uart(1);

  // Compare process, runs mid-cycle so queue pushes are never in flight
  initial begin : compare
    int n;
    n = 0;
    forever begin
      @(negedge clk_i);
      while (got_reply_q.size() > 0) begin
        check_byte(n, exp_reply_q.pop_front(), got_reply_q.pop_front());
        n++;
      end
      for (int ch = 0; ch < `UART_CHANNELS; ch++) begin
        while (uart_got_q[ch].size() > 0) begin
          check_uart(ch, uart_got_q[ch].pop_front());
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CLKS) @(posedge clk_i);
    $display("Run stopped by the watchdog after %0d cycles, the test did not finish",
             WATCHDOG_CLKS);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : stimulus
    logic [7:0] d;
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    spi_clk_i  = 1'b0;
    spi_csb_i  = 1'b1;
    spi_mosi_i = 1'b0;
    seed       = 32'h44bc0977;
    value_errs = 0;
    other_errs = 0;
    next_reply = 8'h00;
    for (int ch = 0; ch < `UART_CHANNELS; ch++) begin
      scratch_m[ch]    = '0;
      count_m[ch]      = '0;
      busy_until_m[ch] = 0.0;
    end
    wait_clks(16);
    arst_n_i = 1'b1;
    wait_clks(2);
    for (int ch = 0; ch < `UART_CHANNELS; ch++) begin
      if (uart_sb[ch].cio_tx !== 1'b1) begin
        other_errs++;
        $display("UART line %0d is not high after reset", ch);
      end
      if (uart_sb[ch].cio_tx_en !== 1'b1) begin
        other_errs++;
        $display("UART line %0d output enable is not set after reset", ch);
      end
    end
    // Scratch write and read back, alternating channels
    for (int i = 0; i < 4; i++) begin
      d = 8'($random(seed));
      run_frame(spi_cmd_pkg::CMD_WRITE, (i % 2 == 1) ? 8'h18 : 8'h08, d);
      run_frame(spi_cmd_pkg::CMD_READ, (i % 2 == 1) ? 8'h18 : 8'h08, 8'h00);
    end
    // One byte out of each channel
    run_frame(spi_cmd_pkg::CMD_WRITE, 8'h00, 8'($random(seed)));
    run_frame(spi_cmd_pkg::CMD_WRITE, 8'h10, 8'($random(seed)));
    // Two bytes on one channel, STATUS straight after the first and after both
    run_frame(spi_cmd_pkg::CMD_WRITE, 8'h00, 8'($random(seed)));
    run_frame(spi_cmd_pkg::CMD_READ, 8'h04, 8'h00);
    run_frame(8'h00, 8'h00, 8'h00);
    run_frame(spi_cmd_pkg::CMD_WRITE, 8'h00, 8'($random(seed)));
    run_frame(8'h00, 8'h00, 8'h00);
    run_frame(spi_cmd_pkg::CMD_READ, 8'h04, 8'h00);
    run_frame(8'h00, 8'h00, 8'h00);
    // Unmapped addresses answer with the error byte
    run_frame(spi_cmd_pkg::CMD_READ, 8'h0C, 8'h00);
    run_frame(spi_cmd_pkg::CMD_READ, 8'h20, 8'h00);
    run_frame(spi_cmd_pkg::CMD_READ, 8'h19, 8'h00);
    run_frame(8'h00, 8'h00, 8'h00);
    // Unknown opcodes aimed at SCRATCH and TXDATA must leave no trace
    run_frame(8'h5A, 8'h18, 8'h77);
    run_frame(8'h01, 8'h00, 8'hA5);
    run_frame(spi_cmd_pkg::CMD_READ, 8'h18, 8'h00);
    run_frame(8'h00, 8'h00, 8'h00);
    while (work_pending()) begin
      @(posedge clk_i);
    end
    // Room for one more UART frame in case a stray byte is on its way
    repeat (UART_FRAME_CLKS) @(posedge clk_i);
    @(negedge clk_i);
    #1;
    asrt_errs = chip_top_i.i_uart_apb_regs.i_chip_top_checker.fail_cnt;
    $display("Checks done: %0d value errors, %0d other failures, %0d assertion failures",
             value_errs, other_errs, asrt_errs);
    if (value_errs == 0 && other_errs == 0 && asrt_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/spi_cmd_pkg.sv
hdl/periph_bus_pkg.sv
hdl/spi_target.sv
hdl/spi_cmd_decoder.sv
hdl/uart_apb_regs.sv
hdl/uart_tx.sv
hdl/chip_top.sv
sim/chip_top_checker.sv
sim/chip_top_tb.sv
